// File: build.f
rtl/eth_readout_pkg.sv
rtl/fifo_if.sv
rtl/sample_packer.sv
rtl/readout_fifo.sv
rtl/frame_builder.sv
rtl/eth_readout_top.sv
testbench/tb_eth_readout.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the readout testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_eth_readout -f build.f -o sim_eth_readout
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_eth_readout)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Test passed" <<< "$sim_out"; then
	exit 0
fi
exit 1

// File: testbench/tb_eth_readout.sv
`timescale 1ns/1ps

module tb_eth_readout;

	localparam int SAMP_COUNT      = 16;
	localparam int FIFO_DEPTH_LOG2 = 7;
	localparam int FRAME_LEN       = SAMP_COUNT + 6;
	localparam int CRC_POS         = SAMP_COUNT + 2;
	localparam int N_EVENTS        = 24;
	localparam int MAX_GAP         = 30;
	localparam int RST_CYCLES      = 3;
	// worst case stimulus plus every frame with its idle cycle and some slack
	localparam int CYCLE_LIMIT = RST_CYCLES + N_EVENTS * (MAX_GAP + SAMP_COUNT + 6)
		+ N_EVENTS * (FRAME_LEN + 1) + 200;

	logic                         RCLK;
	logic                         RST_RESYNC;
	logic                         samp_vld;
	eth_readout_pkg::adc_word_t   samp_data;
	logic                         samp_ovrlp;
	logic                         l1a_vld;
	eth_readout_pkg::l1a_num_t    l1a_num;
	eth_readout_pkg::frame_word_t txd;
	logic                         txd_vld;

	eth_readout_pkg::frame_word_t exp_words[$];  // expected words of all frames in order
	eth_readout_pkg::crc_t        exp_crcs[$];

	int errors;
	int ready_cnt;  // events whose samples and L1A are all driven
	int frames_started;
	int frames_done;
	int cycles;

	eth_readout_top #(
		.SAMP_COUNT      (SAMP_COUNT),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) DUT (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.samp_vld   (samp_vld),
		.samp_data  (samp_data),
		.samp_ovrlp (samp_ovrlp),
		.l1a_vld    (l1a_vld),
		.l1a_num    (l1a_num),
		.txd        (txd),
		.txd_vld    (txd_vld)
	);

	initial begin
		RCLK = 1'b0;
		forever #20 RCLK = ~RCLK;
	end

	task automatic check_word(input string name, input eth_readout_pkg::frame_word_t exp,
		input eth_readout_pkg::frame_word_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_crc(input string name, input eth_readout_pkg::crc_t exp,
		input eth_readout_pkg::crc_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic string word_name(input int frame, input int pos);
		string part;
		if (pos == 0)
			part = "header_hi";
		else if (pos == 1)
			part = "header_lo";
		else if (pos < CRC_POS)
			part = $sformatf("sample %0d", pos - 2);
		else if (pos == CRC_POS)
			part = "crc";
		else if (pos == CRC_POS + 1)
			part = "trailer_a";
		else if (pos == CRC_POS + 2)
			part = "trailer_b";
		else
			part = "trailer_c";
		return $sformatf("frame %0d %s", frame, part);
	endfunction

	// one event and its L1A with the expected frame queued up front
	task automatic send_event(input bit back_to_back, input bit l1a_early);
		eth_readout_pkg::adc_word_t data [SAMP_COUNT];
		logic                       ovr [SAMP_COUNT];
		eth_readout_pkg::l1a_num_t  num;
		eth_readout_pkg::crc_t      crc;
		int                         gap;
		int                         l1a_slot;
		int                         last_i;
		num = eth_readout_pkg::l1a_num_t'($urandom);
		if (back_to_back)
			gap = 0;
		else
			gap = ($urandom % 4 == 0) ? 0 : $urandom % MAX_GAP;
		if (l1a_early)
			l1a_slot = -1 - int'($urandom % 2);
		else
			l1a_slot = int'($urandom % (SAMP_COUNT + 5)) - 2;  // negative means before samples
		last_i = (l1a_slot > SAMP_COUNT - 1) ? l1a_slot : SAMP_COUNT - 1;
		crc    = '0;
		for (int i = 0; i < SAMP_COUNT; i++) begin
			data[i] = eth_readout_pkg::adc_word_t'($urandom);
			ovr[i]  = 1'($urandom);
			crc     = eth_readout_pkg::crc15_d13({ovr[i], data[i]}, crc);
		end
		exp_words.push_back({4'h0, num[23:12]});
		exp_words.push_back({4'h0, num[11:0]});
		for (int i = 0; i < SAMP_COUNT; i++)
			exp_words.push_back({1'b0, ~ovr[i], 2'b00, data[i]});
		exp_words.push_back({1'b0, crc});
		exp_words.push_back(eth_readout_pkg::TRAILER_A);
		exp_words.push_back({4'h7, num[11:0]});
		exp_words.push_back(eth_readout_pkg::TRAILER_C);
		exp_crcs.push_back(crc);
		repeat (gap) @(posedge RCLK);
		for (int i = -2; i <= last_i; i++) begin
			@(posedge RCLK);
			samp_vld <= (i >= 0 && i < SAMP_COUNT);
			if (i >= 0 && i < SAMP_COUNT) begin
				samp_data  <= data[i];
				samp_ovrlp <= ovr[i];
			end
			l1a_vld <= (i == l1a_slot);
			if (i == l1a_slot)
				l1a_num <= num;
		end
		@(posedge RCLK);
		samp_vld <= 1'b0;
		l1a_vld  <= 1'b0;
		ready_cnt++;
	endtask

	// output monitor sampled mid-cycle
	initial begin
		int                           pos;
		bit                           ended;  // last cycle closed a frame
		eth_readout_pkg::frame_word_t exp_w;
		eth_readout_pkg::crc_t        exp_c;
		pos            = 0;
		ended          = 1'b0;
		errors         = 0;
		frames_started = 0;
		frames_done    = 0;
		forever begin
			@(negedge RCLK);
			if (RST_RESYNC) begin
				ended = 1'b0;
			end else if (txd_vld) begin
				if (pos == 0) begin
					if (ended) begin
						errors++;
						$display("frame %0d ran past %0d words with no idle cycle",
							frames_started - 1, FRAME_LEN);
					end
					if (frames_started >= ready_cnt || exp_words.size() == 0) begin
						errors++;
						$display("frame %0d began before its event and L1A were both sent",
							frames_started);
					end
					frames_started++;
				end
				if (exp_words.size() > 0) begin
					exp_w = exp_words.pop_front();
					if (pos == CRC_POS) begin
						exp_c = exp_crcs.pop_front();
						check_crc(word_name(frames_started - 1, pos), exp_c, txd[14:0]);
						if (txd[15] !== 1'b0) begin
							errors++;
							$display("[ERROR] %s top bit expected 0 actual %b",
								word_name(frames_started - 1, pos), txd[15]);
						end
					end else begin
						check_word(word_name(frames_started - 1, pos), exp_w, txd);
					end
				end
				ended = 1'b0;
				pos++;
				if (pos == FRAME_LEN) begin
					pos         = 0;
					frames_done++;
					ended       = 1'b1;
				end
			end else begin
				if (pos != 0) begin
					errors++;
					$display("frame %0d stopped after %0d of %0d words",
						frames_started - 1, pos, FRAME_LEN);
					while (pos < FRAME_LEN) begin  // drop the rest so the next frame lines up
						if (exp_words.size() > 0)
							exp_w = exp_words.pop_front();
						if (pos == CRC_POS && exp_crcs.size() > 0)
							exp_c = exp_crcs.pop_front();
						pos++;
					end
					pos = 0;
					frames_done++;
				end
				ended = 1'b0;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge RCLK);
			cycles++;
		end
		$display("timeout, only %0d of %0d frames arrived within %0d cycles",
			frames_done, N_EVENTS, CYCLE_LIMIT);
		$display("summary: %0d errors, %0d of %0d frames checked", errors, frames_done, N_EVENTS);
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(74));
		RST_RESYNC = 1'b1;
		samp_vld   = 1'b0;
		samp_data  = '0;
		samp_ovrlp = 1'b0;
		l1a_vld    = 1'b0;
		l1a_num    = '0;
		ready_cnt  = 0;
		repeat (RST_CYCLES) @(posedge RCLK);
		RST_RESYNC <= 1'b0;
		for (int k = 0; k < N_EVENTS; k++)
			send_event(k >= 6 && k < 16, k % 5 == 0);  // middle run piles up behind frames
		while (frames_done < N_EVENTS)
			@(posedge RCLK);
		repeat (2 * FRAME_LEN) @(posedge RCLK);  // catch stray frames
		$display("summary: %0d errors, %0d of %0d frames checked", errors, frames_done, N_EVENTS);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: rtl/eth_readout_top.sv
`timescale 1ns/1ps

module eth_readout_top #(
	parameter int SAMP_COUNT      = 16,
	parameter int FIFO_DEPTH_LOG2 = 7
) (
	input  logic                         RCLK,
	input  logic                         RST_RESYNC,
	input  logic                         samp_vld,
	input  eth_readout_pkg::adc_word_t   samp_data,
	input  logic                         samp_ovrlp,
	input  logic                         l1a_vld,
	input  eth_readout_pkg::l1a_num_t    l1a_num,
	output eth_readout_pkg::frame_word_t txd,
	output logic                         txd_vld
);

	localparam int EVT_W = $bits(eth_readout_pkg::evt_word_t);
	localparam int L1A_W = $bits(eth_readout_pkg::l1a_num_t);

	logic evt_done;  // packer to builder, one per completed event

	fifo_if #(.WIDTH(EVT_W)) evt_if ();
	fifo_if #(.WIDTH(L1A_W)) l1a_if ();

	sample_packer #(
		.SAMP_COUNT (SAMP_COUNT)
	) u_packer (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.samp_vld   (samp_vld),
		.samp_data  (samp_data),
		.samp_ovrlp (samp_ovrlp),
		.l1a_vld    (l1a_vld),
		.l1a_num    (l1a_num),
		.evt        (evt_if.writer),
		.l1a        (l1a_if.writer),
		.evt_done   (evt_done)
	);

	// event words
	readout_fifo #(
		.WIDTH           (EVT_W),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) u_evt_fifo (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.port       (evt_if.fifo)
	);

	// trigger numbers
	readout_fifo #(
		.WIDTH           (L1A_W),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) u_l1a_fifo (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.port       (l1a_if.fifo)
	);

	frame_builder #(
		.SAMP_COUNT (SAMP_COUNT)
	) u_builder (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.evt        (evt_if.reader),
		.l1a        (l1a_if.reader),
		.evt_done   (evt_done),
		.txd        (txd),
		.txd_vld    (txd_vld)
	);

endmodule

// File: rtl/frame_builder.sv
`timescale 1ns/1ps

module frame_builder #(
	parameter int SAMP_COUNT = 16
) (
	input  logic                         RCLK,
	input  logic                         RST_RESYNC,
	fifo_if.reader                       evt,
	fifo_if.reader                       l1a,
	input  logic                         evt_done,
	output eth_readout_pkg::frame_word_t txd,
	output logic                         txd_vld
);

	localparam int CNT_W = (SAMP_COUNT > 1) ? $clog2(SAMP_COUNT) : 1;

	eth_readout_pkg::frm_state_t state;
	logic [7:0]                  pend_cnt;  // completed events not yet framed
	logic [CNT_W-1:0]            samp_cnt;
	logic                        last_samp;
	logic                        frm_start;
	eth_readout_pkg::crc_t       crc;
	eth_readout_pkg::evt_word_t  evt_word;
	eth_readout_pkg::l1a_num_t   l1a_cur;

	// read data holds until the next pop, so it stays put for the whole frame
	assign evt_word = evt.dout;
	assign l1a_cur  = l1a.dout;

	assign last_samp = (samp_cnt == CNT_W'(SAMP_COUNT - 1));
	assign frm_start = (state == eth_readout_pkg::FRM_IDLE) && (pend_cnt != '0) && !l1a.empty;

	// L1A popped on the way out of idle
	assign l1a.rd_en = frm_start;

	// event reads run one cycle ahead of the sample words
	assign evt.rd_en = (state == eth_readout_pkg::FRM_HDR_L) ||
		((state == eth_readout_pkg::FRM_SAMP) && !last_samp);

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			pend_cnt <= '0;
		end else begin
			case ({evt_done, frm_start})
				2'b10:   pend_cnt <= pend_cnt + 1'b1;
				2'b01:   pend_cnt <= pend_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state    <= eth_readout_pkg::FRM_IDLE;
			samp_cnt <= '0;
			txd_vld  <= 1'b0;
		end else begin
			txd_vld <= (state != eth_readout_pkg::FRM_IDLE);
			case (state)
				eth_readout_pkg::FRM_IDLE: begin
					if (frm_start)
						state <= eth_readout_pkg::FRM_HDR_H;
				end
				eth_readout_pkg::FRM_HDR_H: begin
					state <= eth_readout_pkg::FRM_HDR_L;
				end
				eth_readout_pkg::FRM_HDR_L: begin
					samp_cnt <= '0;
					state    <= eth_readout_pkg::FRM_SAMP;
				end
				eth_readout_pkg::FRM_SAMP: begin
					samp_cnt <= samp_cnt + 1'b1;
					if (last_samp)
						state <= eth_readout_pkg::FRM_CRC;
				end
				eth_readout_pkg::FRM_CRC: begin
					state <= eth_readout_pkg::FRM_TRL_A;
				end
				eth_readout_pkg::FRM_TRL_A: begin
					state <= eth_readout_pkg::FRM_TRL_B;
				end
				eth_readout_pkg::FRM_TRL_B: begin
					state <= eth_readout_pkg::FRM_TRL_C;
				end
				default: begin
					state <= eth_readout_pkg::FRM_IDLE;  // after last trailer
				end
			endcase
		end
	end

	// output word and CRC, one word per non-idle state cycle
	always_ff @(posedge RCLK) begin
		case (state)
			eth_readout_pkg::FRM_HDR_H: begin
				txd <= {4'h0, l1a_cur[23:12]};
				crc <= '0;  // fresh CRC each frame
			end
			eth_readout_pkg::FRM_HDR_L: begin
				txd <= {4'h0, l1a_cur[11:0]};
			end
			eth_readout_pkg::FRM_SAMP: begin
				txd <= {1'b0, ~evt_word[12], 2'b00, evt_word[11:0]};
				crc <= eth_readout_pkg::crc15_d13(evt_word, crc);
			end
			eth_readout_pkg::FRM_CRC: begin
				txd <= {1'b0, crc};
			end
			eth_readout_pkg::FRM_TRL_A: begin
				txd <= eth_readout_pkg::TRAILER_A;
			end
			eth_readout_pkg::FRM_TRL_B: begin
				txd <= {4'h7, l1a_cur[11:0]};
			end
			eth_readout_pkg::FRM_TRL_C: begin
				txd <= eth_readout_pkg::TRAILER_C;
			end
			default: ;  // idle holds last word
		endcase
	end

endmodule

// File: rtl/readout_fifo.sv
`timescale 1ns/1ps

module readout_fifo #(
	parameter int WIDTH           = 13,
	parameter int FIFO_DEPTH_LOG2 = 7
) (
	input logic RCLK,
	input logic RST_RESYNC,
	fifo_if.fifo port
);

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2:0]   count;  // one extra bit to hold a full count
	logic                       rd_ok;

	assign rd_ok      = port.rd_en && !port.empty;
	assign port.empty = (count == '0);

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (port.wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({port.wr_en, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;  // idle or simultaneous push and pop
			endcase
		end
	end

	// storage and registered read port
	always_ff @(posedge RCLK) begin
		if (port.wr_en)
			mem[wr_ptr] <= port.din;
		if (rd_ok)
			port.dout <= mem[rd_ptr];
	end

endmodule

// File: rtl/sample_packer.sv
`timescale 1ns/1ps

module sample_packer #(
	parameter int SAMP_COUNT = 16
) (
	input  logic                       RCLK,
	input  logic                       RST_RESYNC,
	input  logic                       samp_vld,
	input  eth_readout_pkg::adc_word_t samp_data,
	input  logic                       samp_ovrlp,
	input  logic                       l1a_vld,
	input  eth_readout_pkg::l1a_num_t  l1a_num,
	fifo_if.writer                     evt,
	fifo_if.writer                     l1a,
	output logic                       evt_done
);

	localparam int CNT_W = (SAMP_COUNT > 1) ? $clog2(SAMP_COUNT) : 1;

	logic [CNT_W-1:0]            samp_cnt;  // position within current event
	logic                        last_samp;
	eth_readout_pkg::evt_word_t  samp_word;

	assign samp_word = {samp_ovrlp, samp_data};
	assign last_samp = (samp_cnt == CNT_W'(SAMP_COUNT - 1));

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			evt.wr_en <= 1'b0;
			l1a.wr_en <= 1'b0;
			evt_done  <= 1'b0;
			samp_cnt  <= '0;
		end else begin
			evt.wr_en <= samp_vld;
			l1a.wr_en <= l1a_vld;
			evt_done  <= samp_vld && last_samp;  // same cycle as last word write
			if (samp_vld) begin
				if (last_samp)
					samp_cnt <= '0;
				else
					samp_cnt <= samp_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge RCLK) begin
		if (samp_vld)
			evt.din <= samp_word;
		if (l1a_vld)
			l1a.din <= l1a_num;
	end

endmodule

// File: rtl/fifo_if.sv
`timescale 1ns/1ps

interface fifo_if #(
	parameter int WIDTH = 13
);
	logic             wr_en;
	logic [WIDTH-1:0] din;
	logic             rd_en;
	logic [WIDTH-1:0] dout;  // valid the cycle after rd_en
	logic             empty;

	modport writer (
		output wr_en,
		output din
	);

	modport reader (
		output rd_en,
		input  dout,
		input  empty
	);

	// the FIFO side
	modport fifo (
		input  wr_en,
		input  din,
		input  rd_en,
		output dout,
		output empty
	);

endinterface

// File: rtl/eth_readout_pkg.sv
package eth_readout_pkg;

	// raw ADC sample
	typedef logic [11:0] adc_word_t;

	// bit 12 overlap flag, bits 11..0 sample
	typedef logic [12:0] evt_word_t;

	typedef logic [23:0] l1a_num_t;

	// one word of the outgoing stream
	typedef logic [15:0] frame_word_t;

	typedef logic [14:0] crc_t;

	// builder sequence, one state per emitted word type
	typedef enum logic [2:0] {
		FRM_IDLE,
		FRM_HDR_H,
		FRM_HDR_L,
		FRM_SAMP,
		FRM_CRC,
		FRM_TRL_A,
		FRM_TRL_B,
		FRM_TRL_C
	} frm_state_t;

	// fixed trailer words
	localparam frame_word_t TRAILER_A = 16'h700C;
	localparam frame_word_t TRAILER_C = 16'h7FFF;

	// one step of the CRC-15 register over a 13-bit datum
	// middle taps share one pattern: two data bits, two state bits
	function automatic crc_t crc15_d13(input evt_word_t d, input crc_t c);
		crc_t n;
		n[0] = d[0] ^ c[2];
		for (int i = 1; i <= 12; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage
